// ==== include/cp0_settings.svh ====
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

// datapath and PC width
`define CP0_XLEN 64

// architectural register numbers, all at sel 0
`define CP0_REG_COUNT   5'd9
`define CP0_REG_COMPARE 5'd11
`define CP0_REG_STATUS  5'd12
`define CP0_REG_CAUSE   5'd13
`define CP0_REG_EPC     5'd14

`define CP0_STATUS_RESET 32'h0040_0004  // BEV set, IE/EXL/IM7 clear
`define CP0_STATUS_IM7   15             // timer interrupt mask

// single handler entry, no nested vectors
`define CP0_TRAP_VECTOR 64'hffff_ffff_8000_0180

// ExcCode values
`define CP0_EXC_INT 5'h00
`define CP0_EXC_SYS 5'h08
`define CP0_EXC_BP  5'h09
`define CP0_EXC_RI  5'h0a
`define CP0_EXC_OV  5'h0c

`endif

// ==== hw/cp0_reg_pkg.sv ====
`default_nettype none

`include "cp0_settings.svh"

package cp0_reg_pkg;

    // full-width data and PC values
    typedef logic [`CP0_XLEN-1:0] xlen_t;

    // 32-bit registers: Status, Cause, Count, Compare
    typedef logic [31:0] word_t;

    // mtc0/mfc0 addressing
    typedef logic [4:0] regnum_t;
    typedef logic [2:0] sel_t;

    // Cause.ExcCode field, bits 6:2
    typedef logic [4:0] exc_code_t;

endpackage

`default_nettype wire

// ==== hw/cp0_bus_pkg.sv ====
`default_nettype none

package cp0_bus_pkg;

    // one cycle of core-to-cp0 traffic
    typedef struct packed {
        logic                 mtc0;     // write strobe
        logic                 eret;     // return from handler
        cp0_reg_pkg::regnum_t regnum;
        cp0_reg_pkg::sel_t    sel;
        cp0_reg_pkg::xlen_t   wr_data;
    } cp0_access_t;

    // synchronous exception causes seen this cycle
    typedef struct packed {
        logic overflow;
        logic reserved_inst;
        logic syscall;
        logic break_;
    } exc_event_t;

    // fetch redirect toward the pipeline front end
    typedef struct packed {
        logic               valid;
        cp0_reg_pkg::xlen_t target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== hw/exc_prioritizer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cp0_settings.svh"

module exc_prioritizer (
    input  cp0_bus_pkg::exc_event_t events,
    output logic                    exc_valid,
    output cp0_reg_pkg::exc_code_t  exc_code
);
    import cp0_reg_pkg::*;

    exc_code_t code_sel;

    // any cause at all; EXL masking happens in cp0
    assign exc_valid = |events;

    // fixed priority, overflow wins
    always_comb begin
        code_sel = `CP0_EXC_INT;
        if (events.overflow) begin
            code_sel = `CP0_EXC_OV;
        end else if (events.reserved_inst) begin
            code_sel = `CP0_EXC_RI;
        end else if (events.syscall) begin
            code_sel = `CP0_EXC_SYS;
        end else if (events.break_) begin
            code_sel = `CP0_EXC_BP;
        end
    end

    assign exc_code = code_sel;

endmodule

`default_nettype wire

// ==== hw/cp0_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cp0_settings.svh"

module cp0_timer (
    input  logic                     clock,
    input  logic                     rst_n,
    input  cp0_bus_pkg::cp0_access_t access,
    output cp0_reg_pkg::word_t       count,
    output cp0_reg_pkg::word_t       compare,
    output logic                     timer_irq
);
    import cp0_reg_pkg::*;

    word_t wr_word;
    logic  count_wr;
    logic  compare_wr;
    logic  armed_q;  // compare written at least once
    logic  match;

    assign wr_word = access.wr_data[31:0];  // both registers are 32 bits

    assign count_wr   = access.mtc0 && (access.regnum == `CP0_REG_COUNT) &&
                        (access.sel == '0);
    assign compare_wr = access.mtc0 && (access.regnum == `CP0_REG_COMPARE) &&
                        (access.sel == '0);

    // no match before the first compare write
    assign match = armed_q && (count == compare);

    // free running, wraps
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count_wr) begin
            count <= wr_word;
        end else begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            compare <= '0;
            armed_q <= 1'b0;
        end else if (compare_wr) begin
            compare <= wr_word;
            armed_q <= 1'b1;
        end
    end

    // level held until software rewrites compare
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else if (compare_wr) begin
            timer_irq <= 1'b0;  // acknowledge beats a same-cycle match
        end else if (match) begin
            timer_irq <= 1'b1;
        end
    end

    irq_after_match: assert property (
        @(posedge clock) disable iff (!rst_n)
        $rose(timer_irq) |-> $past(match)
    ) else $error("timer_irq rose without a count/compare match");

endmodule

`default_nettype wire

// ==== hw/cp0.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cp0_settings.svh"

module cp0 (
    input  logic                     clock,
    input  logic                     rst_n,
    input  cp0_bus_pkg::cp0_access_t access,
    input  cp0_reg_pkg::xlen_t       next_pc,
    input  logic                     exc_valid,
    input  cp0_reg_pkg::exc_code_t   exc_code,
    input  logic                     timer_irq,
    input  cp0_reg_pkg::word_t       count,
    input  cp0_reg_pkg::word_t       compare,
    output cp0_reg_pkg::xlen_t       rd_data,
    output cp0_reg_pkg::xlen_t       epc,
    output logic                     trap_taken
);
    import cp0_reg_pkg::*;

    localparam word_t STATUS_RESET = `CP0_STATUS_RESET;

    logic [31:2] status_hi_q;   // status above EXL
    logic        ie_q;          // global interrupt enable
    logic        exl_q;         // kept apart from the rest of status
    exc_code_t   cause_code_q;
    word_t       status_word;
    word_t       cause_word;
    logic        status_wr;
    logic        epc_wr;
    logic        irq_pending;

    assign status_wr = access.mtc0 && (access.regnum == `CP0_REG_STATUS) &&
                       (access.sel == '0);
    assign epc_wr    = access.mtc0 && (access.regnum == `CP0_REG_EPC) &&
                       (access.sel == '0);

    assign status_word = {status_hi_q, exl_q, ie_q};

    // IP7 is the live timer level, rest of the hardware/software bits are zero
    assign cause_word = {16'b0, timer_irq, 8'b0, cause_code_q, 2'b0};

    assign irq_pending = timer_irq && ie_q && status_hi_q[`CP0_STATUS_IM7];

    // taken in the cycle of the cause
    assign trap_taken = !exl_q && (exc_valid || irq_pending);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            status_hi_q <= STATUS_RESET[31:2];
            ie_q        <= STATUS_RESET[0];
        end else if (status_wr && !trap_taken) begin
            status_hi_q <= access.wr_data[31:2];
            ie_q        <= access.wr_data[0];
        end
    end

    // trap first, then eret, then software write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            exl_q <= STATUS_RESET[1];
        end else if (trap_taken) begin
            exl_q <= 1'b1;
        end else if (access.eret) begin
            exl_q <= 1'b0;
        end else if (status_wr) begin
            exl_q <= access.wr_data[1];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            epc <= '0;
        end else if (trap_taken) begin
            epc <= next_pc;  // resume point of the faulting flow
        end else if (epc_wr) begin
            epc <= access.wr_data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cause_code_q <= `CP0_EXC_INT;
        end else if (trap_taken) begin
            // interrupt trap records code 0
            cause_code_q <= exc_valid ? exc_code : `CP0_EXC_INT;
        end
    end

    // sel is ignored on reads
    always_comb begin
        case (access.regnum)
            `CP0_REG_COUNT:   rd_data = xlen_t'(count);
            `CP0_REG_COMPARE: rd_data = xlen_t'(compare);
            `CP0_REG_STATUS:  rd_data = xlen_t'(status_word);
            `CP0_REG_CAUSE:   rd_data = xlen_t'(cause_word);
            `CP0_REG_EPC:     rd_data = epc;
            default:          rd_data = '0;
        endcase
    end

    // input rule on the core side
    no_eret_with_exc: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(access.eret && exc_valid)
    ) else $error("eret and an exception event in the same cycle");

    // a trap enters the handler and blocks a second trap
    trap_sets_exl: assert property (
        @(posedge clock) disable iff (!rst_n)
        trap_taken |=> exl_q && !trap_taken
    ) else $error("trap taken while EXL was set");

endmodule

`default_nettype wire

// ==== hw/trap_redirect.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cp0_settings.svh"

module trap_redirect (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   trap_taken,
    input  logic                   eret,
    input  cp0_reg_pkg::xlen_t     epc,
    output cp0_bus_pkg::redirect_t redirect
);
    import cp0_reg_pkg::*;

    xlen_t target_d;
    xlen_t target_q;
    logic  valid_q;

    // trap goes to the handler, eret returns to the current EPC
    always_comb begin
        if (trap_taken) begin
            target_d = `CP0_TRAP_VECTOR;
        end else begin
            target_d = epc;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= trap_taken || eret;  // one-cycle pulse, never held
        end
    end

    always_ff @(posedge clock) begin
        target_q <= target_d;
    end

    assign redirect = '{valid: valid_q, target: target_q};

    single_cycle_pulse: assert property (
        @(posedge clock) disable iff (!rst_n)
        valid_q && !(trap_taken || eret) |=> !valid_q
    ) else $error("redirect held without a new trap or eret");

endmodule

`default_nettype wire

// ==== hw/cp0_subsystem.sv ====
`default_nettype none
`timescale 1ns/100ps

module cp0_subsystem (
    input  logic                     clock,
    input  logic                     rst_n,
    input  cp0_bus_pkg::cp0_access_t access,
    input  cp0_bus_pkg::exc_event_t  events,
    input  cp0_reg_pkg::xlen_t       next_pc,
    output cp0_reg_pkg::xlen_t       rd_data,
    output cp0_reg_pkg::xlen_t       epc,
    output logic                     trap_taken,
    output cp0_bus_pkg::redirect_t   redirect
);

    logic                   exc_valid;
    cp0_reg_pkg::exc_code_t exc_code;
    cp0_reg_pkg::word_t     count;
    cp0_reg_pkg::word_t     compare;
    logic                   timer_irq;  // IP7

    exc_prioritizer u_exc_prioritizer (
        .events    (events),
        .exc_valid (exc_valid),
        .exc_code  (exc_code)
    );

    cp0_timer u_cp0_timer (
        .clock     (clock),
        .rst_n     (rst_n),
        .access    (access),
        .count     (count),
        .compare   (compare),
        .timer_irq (timer_irq)
    );

    cp0 u_cp0 (
        .clock      (clock),
        .rst_n      (rst_n),
        .access     (access),
        .next_pc    (next_pc),
        .exc_valid  (exc_valid),
        .exc_code   (exc_code),
        .timer_irq  (timer_irq),
        .count      (count),
        .compare    (compare),
        .rd_data    (rd_data),
        .epc        (epc),
        .trap_taken (trap_taken)
    );

    trap_redirect u_trap_redirect (
        .clock      (clock),
        .rst_n      (rst_n),
        .trap_taken (trap_taken),
        .eret       (access.eret),
        .epc        (epc),
        .redirect   (redirect)
    );

endmodule

`default_nettype wire

// ==== test/cp0_checks.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cp0_settings.svh"

module cp0_checks (
    input  logic                     clock,
    input  logic                     rst_n,
    input  cp0_bus_pkg::cp0_access_t access,
    input  cp0_bus_pkg::exc_event_t  events,
    input  cp0_reg_pkg::xlen_t       next_pc,
    input  cp0_reg_pkg::xlen_t       rd_data,
    input  cp0_reg_pkg::xlen_t       epc,
    input  logic                     trap_taken,
    input  cp0_bus_pkg::redirect_t   redirect,
    output logic                     error_seen
);
    import cp0_reg_pkg::*;

    logic  exl_m;  // mirror of Status.EXL
    xlen_t epc_m;  // mirror of EPC
    logic  status_wr;
    logic  epc_wr;

    initial error_seen = 1'b0;

    assign status_wr = access.mtc0 && access.sel == '0 && access.regnum == `CP0_REG_STATUS;
    assign epc_wr    = access.mtc0 && access.sel == '0 && access.regnum == `CP0_REG_EPC;

    // trap beats eret, eret beats a software write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            exl_m <= 1'b0;
        end else if (trap_taken) begin
            exl_m <= 1'b1;
        end else if (access.eret) begin
            exl_m <= 1'b0;
        end else if (status_wr) begin
            exl_m <= access.wr_data[1];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            epc_m <= '0;
        end else if (trap_taken) begin
            epc_m <= next_pc;
        end else if (epc_wr) begin
            epc_m <= access.wr_data;
        end
    end

    task automatic flag_error(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        error_seen = 1'b1;
    endtask

    no_trap_in_handler: assert property (@(posedge clock) disable iff (!rst_n)
        exl_m |-> !trap_taken) else flag_error("trap taken while EXL was set");

    event_traps: assert property (@(posedge clock) disable iff (!rst_n)
        (|events && !exl_m) |-> trap_taken) else flag_error("exception event without a trap");

    epc_tracks: assert property (@(posedge clock) disable iff (!rst_n)
        epc == epc_m) else flag_error("EPC differs from the mirrored value");

    exl_reads_back: assert property (@(posedge clock) disable iff (!rst_n)
        (access.regnum == `CP0_REG_STATUS) |-> rd_data[1] == exl_m)
        else flag_error("Status bit 1 differs from the mirrored EXL");

    trap_redirects: assert property (@(posedge clock) disable iff (!rst_n)
        trap_taken |=> redirect.valid && redirect.target == `CP0_TRAP_VECTOR)
        else flag_error("no redirect to the trap vector after a trap");

    eret_redirects: assert property (@(posedge clock) disable iff (!rst_n)
        (access.eret && !trap_taken) |=> redirect.valid && redirect.target == $past(epc_m))
        else flag_error("no redirect to EPC after ERET");

    redirect_one_shot: assert property (@(posedge clock) disable iff (!rst_n)
        !(trap_taken || access.eret) |=> !redirect.valid)
        else flag_error("redirect valid without a trap or ERET");

endmodule

`default_nettype wire

// ==== test/cp0_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "cp0_settings.svh"

module cp0_tb;
    import cp0_reg_pkg::*;
    import cp0_bus_pkg::*;

    logic        clock;
    logic        rst_n;
    cp0_access_t access;
    exc_event_t  events;
    xlen_t       next_pc;
    xlen_t       rd_data;
    xlen_t       epc;
    logic        trap_taken;
    redirect_t   redirect;
    logic        check_error;
    integer      seed;
    word_t       status_val;  // last Status written with EXL clear
    word_t       cnt;
    xlen_t       rnd;
    xlen_t       pc;
    exc_event_t  ev;

    cp0_subsystem DUT (
        .clock(clock), .rst_n(rst_n), .access(access), .events(events),
        .next_pc(next_pc), .rd_data(rd_data), .epc(epc),
        .trap_taken(trap_taken), .redirect(redirect)
    );

    cp0_checks checks (
        .clock(clock), .rst_n(rst_n), .access(access), .events(events),
        .next_pc(next_pc), .rd_data(rd_data), .epc(epc), .trap_taken(trap_taken),
        .redirect(redirect), .error_seen(check_error)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stop_run(input string why);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic fail_value(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        stop_run("a register or redirect value was wrong");
    endtask

    always @(posedge check_error) begin
        stop_run("a checker assertion failed");
    end

    // overflow, then RI, then syscall, then break
    function automatic exc_code_t expected_code(input exc_event_t e);
        if (e.overflow) return 5'h0c;
        if (e.reserved_inst) return 5'h0a;
        if (e.syscall) return 5'h08;
        return 5'h09;
    endfunction

    // idle read cycle on one register sampled just after the falling edge
    task automatic select_reg(input regnum_t r);
        @(negedge clock);
        access = '0;
        access.regnum = r;
        events = '0;
        #1;
    endtask

    task automatic write_reg(input regnum_t r, input sel_t s, input xlen_t d);
        @(negedge clock);
        access = '{mtc0: 1'b1, eret: 1'b0, regnum: r, sel: s, wr_data: d};
        events = '0;
    endtask

    task automatic expect_reg(input regnum_t r, input xlen_t exp, input string what);
        select_reg(r);
        assert (rd_data == exp)
            else fail_value($sformatf("%s read %h, expected %h", what, rd_data, exp));
    endtask

    task automatic return_from_trap(input xlen_t target);
        @(negedge clock);
        access = '0;
        access.eret = 1'b1;
        events = '0;
        select_reg(`CP0_REG_STATUS);
        assert (rd_data == xlen_t'(status_val)) else fail_value("EXL still set after ERET");
        assert (redirect.valid && redirect.target == target)
            else fail_value("ERET redirect missing or wrong target");
    endtask

    task automatic wait_trap(input int limit);
        int waited;
        waited = 0;
        do begin
            if (waited == limit) stop_run("timeout waiting for trap_taken");
            select_reg(`CP0_REG_CAUSE);
            waited++;
        end while (!trap_taken);
    endtask

    task automatic wait_ip7_without_trap(input int limit);
        int waited;
        waited = 0;
        do begin
            if (waited == limit) stop_run("timeout waiting for Cause bit 15");
            select_reg(`CP0_REG_CAUSE);
            assert (!trap_taken) else fail_value("timer trap taken with IE clear");
            waited++;
        end while (!rd_data[15]);
    endtask

    initial begin
        seed = 32'h44cb8272;
        rst_n = 1'b0;
        access = '0;
        events = '0;
        next_pc = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        expect_reg(`CP0_REG_STATUS, 64'h0040_0004, "Status after reset");
        expect_reg(`CP0_REG_CAUSE, '0, "Cause after reset");
        expect_reg(`CP0_REG_EPC, '0, "EPC after reset");
        expect_reg(`CP0_REG_COMPARE, '0, "Compare after reset");
        assert (!trap_taken && !redirect.valid) else fail_value("trap or redirect after reset");

        rnd = {$random(seed), $random(seed)} & 64'hffff_ffff_ffff_7ffc;  // IE, EXL, IM7 clear
        status_val = rnd[31:0];
        write_reg(`CP0_REG_STATUS, 3'd0, rnd);
        expect_reg(`CP0_REG_STATUS, xlen_t'(status_val), "Status write");
        write_reg(`CP0_REG_STATUS, 3'd2, ~rnd);
        expect_reg(`CP0_REG_STATUS, xlen_t'(status_val), "Status write with sel 2");
        rnd = {$random(seed), $random(seed)};
        write_reg(`CP0_REG_EPC, 3'd0, rnd);
        expect_reg(`CP0_REG_EPC, rnd, "EPC write");
        write_reg(`CP0_REG_EPC, 3'd7, ~rnd);
        expect_reg(`CP0_REG_EPC, rnd, "EPC write with sel 7");
        rnd = {$random(seed), $random(seed)};
        write_reg(`CP0_REG_COMPARE, 3'd0, rnd);
        expect_reg(`CP0_REG_COMPARE, {32'b0, rnd[31:0]}, "Compare write");
        write_reg(`CP0_REG_COMPARE, 3'd1, ~rnd);
        expect_reg(`CP0_REG_COMPARE, {32'b0, rnd[31:0]}, "Compare write with sel 1");

        for (int i = 0; i < 8; i++) begin
            rnd = {$random(seed), $random(seed)};
            ev = rnd[3:0];
            if (ev == '0) ev.break_ = 1'b1;
            pc = {$random(seed), $random(seed)};
            @(negedge clock);
            access = '0;
            events = ev;
            next_pc = pc;
            #1;
            assert (trap_taken) else fail_value("exception events gave no trap");
            select_reg(`CP0_REG_CAUSE);
            assert (rd_data[6:2] == expected_code(ev)) else fail_value("wrong Cause ExcCode");
            assert (redirect.valid && redirect.target == `CP0_TRAP_VECTOR)
                else fail_value("trap redirect missing or wrong target");
            expect_reg(`CP0_REG_EPC, pc, "EPC after trap");
            expect_reg(`CP0_REG_STATUS, xlen_t'(status_val | 32'h2), "Status after trap");
            @(negedge clock);
            events = ev;  // no second trap while EXL is set
            next_pc = ~pc;
            #1;
            assert (!trap_taken) else fail_value("trap taken inside the handler");
            return_from_trap(pc);
        end

        // timer interrupt with IE and IM7 enabled
        status_val = 32'h0040_8005;
        write_reg(`CP0_REG_STATUS, 3'd0, xlen_t'(status_val));
        select_reg(`CP0_REG_COUNT);
        cnt = rd_data[31:0];
        pc = {$random(seed), $random(seed)};
        write_reg(`CP0_REG_COMPARE, 3'd0, xlen_t'(cnt + 32'd8));
        next_pc = pc;
        wait_trap(40);
        select_reg(`CP0_REG_CAUSE);
        assert (rd_data[15] && rd_data[6:2] == 5'h00) else fail_value("timer trap Cause wrong");
        write_reg(`CP0_REG_COMPARE, 3'd0, xlen_t'(cnt - 32'd1));
        select_reg(`CP0_REG_CAUSE);
        assert (!rd_data[15]) else fail_value("Cause bit 15 still set after Compare write");
        return_from_trap(pc);

        // same match with IE clear
        status_val = 32'h0040_8004;
        write_reg(`CP0_REG_STATUS, 3'd0, xlen_t'(status_val));
        select_reg(`CP0_REG_COUNT);
        cnt = rd_data[31:0];
        write_reg(`CP0_REG_COMPARE, 3'd0, xlen_t'(cnt + 32'd6));
        wait_ip7_without_trap(40);
        write_reg(`CP0_REG_COMPARE, 3'd0, xlen_t'(cnt - 32'd1));
        select_reg(`CP0_REG_CAUSE);
        assert (!rd_data[15] && !trap_taken)
            else fail_value("Cause bit 15 still set after Compare write with IE clear");

        @(negedge clock);
        if (check_error) begin
            stop_run("a checker assertion failed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hw/cp0_reg_pkg.sv
hw/cp0_bus_pkg.sv
hw/exc_prioritizer.sv
hw/cp0_timer.sv
hw/cp0.sv
hw/trap_redirect.sv
hw/cp0_subsystem.sv
test/cp0_checks.sv
test/cp0_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cp0 testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module cp0_tb -o cp0_sim

status=0
./obj_dir/cp0_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
